// File: design/fe_pkg.sv
// front-end package with widths, queue depths, reset pc and opcode classes
package fe_pkg;

  // instruction and pc widths
  localparam int unsigned ILEN = 32;
  localparam int unsigned PLEN = 32;

  // a fetch group is four aligned words, a decode bundle two
  localparam int unsigned FETCH_WIDTH  = 4;
  localparam int unsigned DECODE_WIDTH = 2;

  // queue entries hold single instructions; keep this a power of two
  localparam int unsigned IB_DEPTH = 16;

  // instruction memory, indexed by pc[9:2]
  localparam int unsigned IMEM_WORDS = 256;
  localparam int unsigned IMEM_AW    = 8;

  localparam logic [PLEN-1:0] RESET_PC = '0;

  // derived sizes
  localparam int unsigned INSTR_BYTES = ILEN / 8;
  localparam int unsigned GROUP_BYTES = FETCH_WIDTH * INSTR_BYTES;
  localparam int unsigned GROUP_OFS_W = $clog2(GROUP_BYTES);
  localparam int unsigned FG_IDX_W    = $clog2(FETCH_WIDTH);
  localparam int unsigned GROUP_AW    = IMEM_AW - FG_IDX_W;

  // buffer pointer and counter widths
  localparam int unsigned IB_PTR_W   = $clog2(IB_DEPTH);
  localparam int unsigned IB_CNT_W   = $clog2(IB_DEPTH + 1);
  localparam int unsigned PEND_CNT_W = $clog2(FETCH_WIDTH + 1);

  // major opcode classes seen by the decoder
  typedef enum logic [3:0] {
    OPC_LOAD,
    OPC_STORE,
    OPC_BRANCH,
    OPC_JAL,
    OPC_JALR,
    OPC_OP_IMM,
    OPC_OP,
    OPC_LUI,
    OPC_AUIPC,
    OPC_SYSTEM,
    // anything else, including compressed encodings
    OPC_ILLEGAL
  } op_class_e;

endpackage

// File: design/fetch_frontend.sv
// front-end top joining memory, fetch unit, instruction buffer and decoder
`timescale 1ns/10ps

module fetch_frontend (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,

  input  logic                                              load_we_i,
  input  logic [fe_pkg::IMEM_AW-1:0]                        load_addr_i,
  input  logic [fe_pkg::ILEN-1:0]                           load_data_i,

  input  logic                                              redirect_i,
  input  logic [fe_pkg::PLEN-1:0]                           redirect_pc_i,

  output logic                                              dec_valid_o,
  input  logic                                              dec_ready_i,
  output logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::ILEN-1:0] dec_instrs_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::PLEN-1:0] dec_pcs_o,
  output fe_pkg::op_class_e [fe_pkg::DECODE_WIDTH-1:0]      dec_class_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0][4:0]              dec_rd_o
);

  // memory read path
  logic                                             rd_en;
  logic [fe_pkg::GROUP_AW-1:0]                      rd_group_addr;
  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] rd_data;

  // fetch groups
  logic                                             fe_valid;
  logic                                             fe_ready;
  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] fe_instrs;
  logic [fe_pkg::PLEN-1:0]                          fe_pc;

  // bundles
  logic                                              ibuf_valid;
  logic                                              ibuf_ready;
  logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::ILEN-1:0] ibuf_instrs;
  logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::PLEN-1:0] ibuf_pcs;

  imem u_imem (
    .clk_i           (clk_i),
    .rd_en_i         (rd_en),
    .rd_group_addr_i (rd_group_addr),
    .rd_data_o       (rd_data),
    .load_we_i       (load_we_i),
    .load_addr_i     (load_addr_i),
    .load_data_i     (load_data_i)
  );

  fetch_unit u_fetch_unit (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .redirect_i      (redirect_i),
    .redirect_pc_i   (redirect_pc_i),
    .rd_en_o         (rd_en),
    .rd_group_addr_o (rd_group_addr),
    .rd_data_i       (rd_data),
    .fe_valid_o      (fe_valid),
    .fe_ready_i      (fe_ready),
    .fe_instrs_o     (fe_instrs),
    .fe_pc_o         (fe_pc)
  );

  // a redirect also flushes everything already buffered
  ibuffer u_ibuffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fe_valid_i    (fe_valid),
    .fe_ready_o    (fe_ready),
    .fe_instrs_i   (fe_instrs),
    .fe_pc_i       (fe_pc),
    .ibuf_valid_o  (ibuf_valid),
    .ibuf_ready_i  (ibuf_ready),
    .ibuf_instrs_o (ibuf_instrs),
    .ibuf_pcs_o    (ibuf_pcs),
    .flush_i       (redirect_i)
  );

  instr_decoder u_instr_decoder (
    .ibuf_valid_i  (ibuf_valid),
    .ibuf_ready_o  (ibuf_ready),
    .ibuf_instrs_i (ibuf_instrs),
    .ibuf_pcs_i    (ibuf_pcs),
    .dec_valid_o   (dec_valid_o),
    .dec_ready_i   (dec_ready_i),
    .dec_instrs_o  (dec_instrs_o),
    .dec_pcs_o     (dec_pcs_o),
    .dec_class_o   (dec_class_o),
    .dec_rd_o      (dec_rd_o)
  );

endmodule

// File: design/fetch_unit.sv
// fetch unit issuing group reads, holding stalled groups and taking redirects
`timescale 1ns/10ps

module fetch_unit (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,

  input  logic                                             redirect_i,
  input  logic [fe_pkg::PLEN-1:0]                          redirect_pc_i,

  // to the instruction memory
  output logic                                             rd_en_o,
  output logic [fe_pkg::GROUP_AW-1:0]                      rd_group_addr_o,
  input  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] rd_data_i,

  // fetch groups towards the instruction buffer
  output logic                                             fe_valid_o,
  input  logic                                             fe_ready_i,
  output logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] fe_instrs_o,
  output logic [fe_pkg::PLEN-1:0]                          fe_pc_o
);

  // hold register state: empty, waiting on a read, or holding a group
  typedef enum logic [1:0] {
    FE_IDLE,
    FE_REFILL,
    FE_HOLD
  } fe_state_e;

  fe_state_e state_q;

  logic [fe_pkg::PLEN-1:0] pc_q;
  logic [fe_pkg::PLEN-1:0] rd_pc_q;
  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] hold_instrs_q;
  logic [fe_pkg::PLEN-1:0] hold_pc_q;
  logic stuck;

  // in REFILL the returning group is offered straight from the memory
  assign fe_valid_o  = (state_q != FE_IDLE);
  assign fe_instrs_o = (state_q == FE_HOLD) ? hold_instrs_q : rd_data_i;
  assign fe_pc_o     = (state_q == FE_HOLD) ? hold_pc_q : rd_pc_q;

  // group stays behind this cycle
  assign stuck = fe_valid_o && !fe_ready_i;

  // only read when the result has somewhere to land next cycle
  assign rd_en_o         = rst_ni && !redirect_i && !stuck;
  assign rd_group_addr_o = pc_q[fe_pkg::GROUP_OFS_W +: fe_pkg::GROUP_AW];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FE_IDLE;
      pc_q    <= fe_pkg::RESET_PC;
    end else if (redirect_i) begin
      // drop the held group and any read in flight
      state_q <= FE_IDLE;
      pc_q    <= redirect_pc_i & ~fe_pkg::PLEN'(fe_pkg::GROUP_BYTES - 1);
    end else if (stuck) begin
      state_q <= FE_HOLD;
    end else begin
      state_q <= FE_REFILL;
      pc_q    <= pc_q + fe_pkg::PLEN'(fe_pkg::GROUP_BYTES);
    end
  end

  // pc of the read in flight, and the group parked under back-pressure
  always_ff @(posedge clk_i) begin
    if (rd_en_o) begin
      rd_pc_q <= pc_q;
    end
    if (state_q == FE_REFILL && stuck) begin
      hold_instrs_q <= rd_data_i;
      hold_pc_q     <= rd_pc_q;
    end
  end

  // a stalled group must not change under the buffer
  property p_stall_stable;
    @(posedge clk_i) disable iff (!rst_ni)
      fe_valid_o && !fe_ready_i && !redirect_i |=> fe_valid_o && $stable(fe_pc_o);
  endproperty

  a_stall_stable : assert property (p_stall_stable)
    else $error("fetch group changed while stalled");

endmodule

// File: design/ibuffer.sv
// instruction buffer splitting fetch groups into entries and issuing decode bundles
`timescale 1ns/10ps

module ibuffer (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,

  // fetch groups in
  input  logic                                              fe_valid_i,
  output logic                                              fe_ready_o,
  input  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0]  fe_instrs_i,
  input  logic [fe_pkg::PLEN-1:0]                           fe_pc_i,

  // decode bundles out
  output logic                                              ibuf_valid_o,
  input  logic                                              ibuf_ready_i,
  output logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::ILEN-1:0] ibuf_instrs_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::PLEN-1:0] ibuf_pcs_o,

  input  logic                                              flush_i
);

  // circular queue of single instructions
  logic [fe_pkg::ILEN-1:0] q_instr_q [fe_pkg::IB_DEPTH];
  logic [fe_pkg::PLEN-1:0] q_pc_q [fe_pkg::IB_DEPTH];

  logic [fe_pkg::IB_PTR_W-1:0] wr_ptr_q;
  logic [fe_pkg::IB_PTR_W-1:0] rd_ptr_q;
  logic [fe_pkg::IB_CNT_W-1:0] count_q;
  logic [fe_pkg::IB_CNT_W-1:0] pop_n;
  logic [fe_pkg::IB_CNT_W-1:0] free_n;

  // pending group and the next slot still to be moved
  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] pend_instrs_q;
  logic [fe_pkg::PLEN-1:0] pend_pc_q;
  logic [fe_pkg::PEND_CNT_W-1:0] pend_cnt_q;
  logic [fe_pkg::FG_IDX_W-1:0] pend_ofs_q;

  // pending view after this cycle's accept
  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] src_instrs;
  logic [fe_pkg::PLEN-1:0] src_pc;
  logic [fe_pkg::PEND_CNT_W-1:0] src_cnt;
  logic [fe_pkg::FG_IDX_W-1:0] src_ofs;
  logic [fe_pkg::PEND_CNT_W-1:0] push_n;

  logic fe_fire;
  logic pop;

  // per-slot queue writes
  logic [fe_pkg::FETCH_WIDTH-1:0] wr_en;
  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::FG_IDX_W-1:0] wr_slot;
  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::IB_PTR_W-1:0] wr_idx;
  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] wr_instr;
  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::PLEN-1:0] wr_pc;
  logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::IB_PTR_W-1:0] rd_idx;

  assign fe_ready_o   = !flush_i && (pend_cnt_q == '0);
  assign fe_fire      = fe_valid_i && fe_ready_o;
  // a bundle is only ever a full pair
  assign ibuf_valid_o = !flush_i && (count_q >= fe_pkg::IB_CNT_W'(fe_pkg::DECODE_WIDTH));
  assign pop          = ibuf_valid_o && ibuf_ready_i;

  assign pop_n  = pop ? fe_pkg::IB_CNT_W'(fe_pkg::DECODE_WIDTH) : '0;
  // space left, counting what the leaving bundle frees
  assign free_n = fe_pkg::IB_CNT_W'(fe_pkg::IB_DEPTH) - count_q + pop_n;

  // a newly accepted group moves in the same cycle
  assign src_instrs = fe_fire ? fe_instrs_i : pend_instrs_q;
  assign src_pc     = fe_fire ? fe_pc_i : pend_pc_q;
  assign src_cnt    = fe_fire ? fe_pkg::PEND_CNT_W'(fe_pkg::FETCH_WIDTH) : pend_cnt_q;
  assign src_ofs    = fe_fire ? '0 : pend_ofs_q;

  assign push_n = (fe_pkg::IB_CNT_W'(src_cnt) <= free_n) ? src_cnt
                                                         : fe_pkg::PEND_CNT_W'(free_n);

  always_comb begin
    for (int unsigned i = 0; i < fe_pkg::FETCH_WIDTH; i++) begin
      wr_slot[i]  = src_ofs + fe_pkg::FG_IDX_W'(i);
      wr_en[i]    = !flush_i && (i < push_n);
      wr_idx[i]   = wr_ptr_q + fe_pkg::IB_PTR_W'(i);
      wr_instr[i] = src_instrs[wr_slot[i]];
      // fixed 4-byte instructions
      wr_pc[i]    = src_pc + fe_pkg::PLEN'(wr_slot[i]) * fe_pkg::PLEN'(fe_pkg::INSTR_BYTES);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      pend_cnt_q <= '0;
      pend_ofs_q <= '0;
    end else if (flush_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      pend_cnt_q <= '0;
      pend_ofs_q <= '0;
    end else begin
      wr_ptr_q   <= wr_ptr_q + fe_pkg::IB_PTR_W'(push_n);
      rd_ptr_q   <= rd_ptr_q + fe_pkg::IB_PTR_W'(pop_n);
      count_q    <= count_q + fe_pkg::IB_CNT_W'(push_n) - pop_n;
      pend_cnt_q <= src_cnt - push_n;
      pend_ofs_q <= src_ofs + fe_pkg::FG_IDX_W'(push_n);
    end
  end

  always_ff @(posedge clk_i) begin
    if (fe_fire) begin
      pend_instrs_q <= fe_instrs_i;
      pend_pc_q     <= fe_pc_i;
    end
    for (int unsigned i = 0; i < fe_pkg::FETCH_WIDTH; i++) begin
      if (wr_en[i]) begin
        q_instr_q[wr_idx[i]] <= wr_instr[i];
        q_pc_q[wr_idx[i]]    <= wr_pc[i];
      end
    end
  end

  // head of queue, read combinationally
  always_comb begin
    for (int unsigned j = 0; j < fe_pkg::DECODE_WIDTH; j++) begin
      rd_idx[j]        = rd_ptr_q + fe_pkg::IB_PTR_W'(j);
      ibuf_instrs_o[j] = q_instr_q[rd_idx[j]];
      ibuf_pcs_o[j]    = q_pc_q[rd_idx[j]];
    end
  end

  a_count_bound : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      count_q <= fe_pkg::IB_CNT_W'(fe_pkg::IB_DEPTH))
    else $error("instruction buffer count overflow");

  // entries still draining keep their group until the last one has moved
  a_pend_blocks : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      pend_cnt_q != '0 |=> $stable(pend_pc_q) && $stable(pend_instrs_q))
    else $error("fetch group accepted over pending entries");

endmodule

// File: design/imem.sv
// instruction memory returning one aligned four-word group per read
`timescale 1ns/10ps

module imem (
  input  logic                                             clk_i,

  // group read port
  input  logic                                             rd_en_i,
  input  logic [fe_pkg::GROUP_AW-1:0]                      rd_group_addr_i,
  output logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] rd_data_o,

  // word load port
  input  logic                                             load_we_i,
  input  logic [fe_pkg::IMEM_AW-1:0]                       load_addr_i,
  input  logic [fe_pkg::ILEN-1:0]                          load_data_i
);

  logic [fe_pkg::ILEN-1:0] mem_q [fe_pkg::IMEM_WORDS];

  // word address of each slot in the requested group
  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::IMEM_AW-1:0] word_addr;

  always_comb begin
    for (int unsigned w = 0; w < fe_pkg::FETCH_WIDTH; w++) begin
      word_addr[w] = {rd_group_addr_i, fe_pkg::FG_IDX_W'(w)};
    end
  end

  // one word per load strobe
  always_ff @(posedge clk_i) begin
    if (load_we_i) begin
      mem_q[load_addr_i] <= load_data_i;
    end
  end

  // all four words come back together on the next cycle
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      for (int unsigned w = 0; w < fe_pkg::FETCH_WIDTH; w++) begin
        rd_data_o[w] <= mem_q[word_addr[w]];
      end
    end
  end

endmodule

// File: design/instr_decoder.sv
// instruction decoder giving each bundle slot an opcode class and destination register
`timescale 1ns/10ps

module instr_decoder (
  // bundles from the instruction buffer
  input  logic                                              ibuf_valid_i,
  output logic                                              ibuf_ready_o,
  input  logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::ILEN-1:0] ibuf_instrs_i,
  input  logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::PLEN-1:0] ibuf_pcs_i,

  // decoded bundles out
  output logic                                              dec_valid_o,
  input  logic                                              dec_ready_i,
  output logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::ILEN-1:0] dec_instrs_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::PLEN-1:0] dec_pcs_o,
  output fe_pkg::op_class_e [fe_pkg::DECODE_WIDTH-1:0]      dec_class_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0][4:0]              dec_rd_o
);

  fe_pkg::op_class_e [fe_pkg::DECODE_WIDTH-1:0] slot_class;

  // handshake and payload pass through untouched
  assign dec_valid_o  = ibuf_valid_i;
  assign ibuf_ready_o = dec_ready_i;
  assign dec_instrs_o = ibuf_instrs_i;
  assign dec_pcs_o    = ibuf_pcs_i;
  assign dec_class_o  = slot_class;

  always_comb begin
    for (int unsigned s = 0; s < fe_pkg::DECODE_WIDTH; s++) begin
      // major opcode, low two bits must be 11
      case (ibuf_instrs_i[s][6:0])
        7'b0000011: slot_class[s] = fe_pkg::OPC_LOAD;
        7'b0100011: slot_class[s] = fe_pkg::OPC_STORE;
        7'b1100011: slot_class[s] = fe_pkg::OPC_BRANCH;
        7'b1101111: slot_class[s] = fe_pkg::OPC_JAL;
        7'b1100111: slot_class[s] = fe_pkg::OPC_JALR;
        7'b0010011: slot_class[s] = fe_pkg::OPC_OP_IMM;
        7'b0110011: slot_class[s] = fe_pkg::OPC_OP;
        7'b0110111: slot_class[s] = fe_pkg::OPC_LUI;
        7'b0010111: slot_class[s] = fe_pkg::OPC_AUIPC;
        7'b1110011: slot_class[s] = fe_pkg::OPC_SYSTEM;
        default:    slot_class[s] = fe_pkg::OPC_ILLEGAL;
      endcase

      // no register write for these classes
      case (slot_class[s])
        fe_pkg::OPC_STORE,
        fe_pkg::OPC_BRANCH,
        fe_pkg::OPC_SYSTEM,
        fe_pkg::OPC_ILLEGAL: dec_rd_o[s] = '0;
        default:             dec_rd_o[s] = ibuf_instrs_i[s][11:7];
      endcase
    end
  end

endmodule

// File: fetch_frontend.f
+incdir+tb
design/fe_pkg.sv
design/imem.sv
design/fetch_unit.sv
design/ibuffer.sv
design/instr_decoder.sv
design/fetch_frontend.sv
tb/tb_fetch_frontend.sv

// File: run_sim.sh
#!/bin/sh
# build and run the front-end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fetch_frontend \
  -f fetch_frontend.f \
  -o sim_fetch_frontend

./obj_dir/sim_fetch_frontend > sim.log
cat sim.log

if grep -qx "Simulation completed successfully" sim.log; then
  exit 0
fi
exit 1

// File: tb/fe_ref.svh
// reference decode rules and memory shadow for the front-end testbench
`ifndef FE_REF_SVH
`define FE_REF_SVH

// copy of every word written through the load port
logic [31:0] shadow_mem [256];

// memory wraps every 1024 bytes, word index is pc[9:2]
function automatic logic [31:0] shadow_word(input logic [31:0] pc);
  return shadow_mem[pc[9:2]];
endfunction

// opcode class from the major opcode, 32-bit encodings only
function automatic fe_pkg::op_class_e ref_class(input logic [31:0] instr);
  fe_pkg::op_class_e cls;
  cls = fe_pkg::OPC_ILLEGAL;
  if (instr[1:0] == 2'b11) begin
    case (instr[6:2])
      5'b00000: cls = fe_pkg::OPC_LOAD;
      5'b01000: cls = fe_pkg::OPC_STORE;
      5'b11000: cls = fe_pkg::OPC_BRANCH;
      5'b11011: cls = fe_pkg::OPC_JAL;
      5'b11001: cls = fe_pkg::OPC_JALR;
      5'b00100: cls = fe_pkg::OPC_OP_IMM;
      5'b01100: cls = fe_pkg::OPC_OP;
      5'b01101: cls = fe_pkg::OPC_LUI;
      5'b00101: cls = fe_pkg::OPC_AUIPC;
      5'b11100: cls = fe_pkg::OPC_SYSTEM;
      default:  cls = fe_pkg::OPC_ILLEGAL;
    endcase
  end
  return cls;
endfunction

// destination register, zero when the class writes no register
function automatic logic [4:0] ref_rd(input logic [31:0] instr);
  fe_pkg::op_class_e cls;
  cls = ref_class(instr);
  if (cls == fe_pkg::OPC_STORE || cls == fe_pkg::OPC_BRANCH ||
      cls == fe_pkg::OPC_SYSTEM || cls == fe_pkg::OPC_ILLEGAL) begin
    return 5'd0;
  end
  return instr[11:7];
endfunction

`endif

// File: tb/tb_fetch_frontend.sv
// testbench for the fetch front end with a scoreboard on the decoded bundles
`timescale 1ns/10ps

module tb_fetch_frontend;

  `include "fe_ref.svh"

  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned SEED         = 25038;

  logic clk_i;
  logic rst_ni;
  logic load_we_i;
  logic [fe_pkg::IMEM_AW-1:0] load_addr_i;
  logic [fe_pkg::ILEN-1:0] load_data_i;
  logic redirect_i;
  logic [fe_pkg::PLEN-1:0] redirect_pc_i;
  logic dec_valid_o;
  logic dec_ready_i;
  logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::ILEN-1:0] dec_instrs_o;
  logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::PLEN-1:0] dec_pcs_o;
  fe_pkg::op_class_e [fe_pkg::DECODE_WIDTH-1:0] dec_class_o;
  logic [fe_pkg::DECODE_WIDTH-1:0][4:0] dec_rd_o;

  // valid and invalid major opcodes for the random program
  logic [6:0] opcode_table [14] = '{
    7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111, 7'b1100111,
    7'b0010011, 7'b0110011, 7'b0110111, 7'b0010111, 7'b1110011,
    7'b0001111, 7'b0101111, 7'b1111111, 7'b0000010
  };

  int unsigned errors;
  int unsigned checks;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned bundle_cnt;
  int unsigned quiet_left;
  logic [31:0] exp_pc;
  bit class_seen [16];

  fetch_frontend dut_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .load_we_i     (load_we_i),
    .load_addr_i   (load_addr_i),
    .load_data_i   (load_data_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .dec_valid_o   (dec_valid_o),
    .dec_ready_i   (dec_ready_i),
    .dec_instrs_o  (dec_instrs_o),
    .dec_pcs_o     (dec_pcs_o),
    .dec_class_o   (dec_class_o),
    .dec_rd_o      (dec_rd_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %0d ns: %s mismatch, got %h expected %h", $time, what, got, exp);
    end
  endtask

  // both slots of an accepted bundle against the expected stream
  task automatic check_bundle();
    logic [31:0] pc_exp;
    logic [31:0] word;
    fe_pkg::op_class_e cls;
    for (int s = 0; s < fe_pkg::DECODE_WIDTH; s++) begin
      pc_exp = exp_pc + 32'(4 * s);
      word   = shadow_word(pc_exp);
      cls    = ref_class(word);
      check_value("pc", dec_pcs_o[s], pc_exp);
      check_value("instruction", dec_instrs_o[s], word);
      check_value("class", 32'(dec_class_o[s]), 32'(cls));
      check_value("rd", 32'(dec_rd_o[s]), 32'(ref_rd(word)));
      class_seen[cls] = 1'b1;
    end
    exp_pc = exp_pc + 32'd8;
    bundle_cnt++;
  endtask

  // scoreboard, samples settled values at the clock edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (redirect_i) begin
        check_value("dec_valid_o in redirect cycle", 32'(dec_valid_o), 32'd0);
        exp_pc = redirect_pc_i & ~32'hF;
        quiet_left = 2;
      end else begin
        if (quiet_left != 0) begin
          check_value("dec_valid_o after redirect", 32'(dec_valid_o), 32'd0);
          quiet_left--;
        end
        if (dec_valid_o && dec_ready_i) begin
          check_bundle();
        end
      end
    end
  end

  task automatic step(input bit bp);
    @(posedge clk_i);
    dec_ready_i <= bp ? 1'($urandom() % 2) : 1'b1;
  endtask

  task automatic wait_bundles(input int unsigned n, input bit bp, input string what);
    int unsigned start;
    int unsigned cycles;
    start  = bundle_cnt;
    cycles = 0;
    while (bundle_cnt - start < n && cycles < n * 20 + 50) begin
      step(bp);
      cycles++;
    end
    if (bundle_cnt - start < n) begin
      errors++;
      $display("timeout in %s: only %0d of %0d bundles arrived", what, bundle_cnt - start, n);
    end
  endtask

  task automatic issue_redirect(input logic [31:0] target, input bit bp);
    step(bp);
    redirect_i    <= 1'b1;
    redirect_pc_i <= target;
    step(bp);
    redirect_i <= 1'b0;
    step(bp);
  endtask

  task automatic load_memory();
    logic [31:0] rnd;
    logic [31:0] word;
    for (int unsigned a = 0; a < fe_pkg::IMEM_WORDS; a++) begin
      @(posedge clk_i);
      rnd  = $urandom();
      word = {rnd[31:7], opcode_table[$urandom() % 14]};
      load_we_i   <= 1'b1;
      load_addr_i <= fe_pkg::IMEM_AW'(a);
      load_data_i <= word;
      shadow_mem[a] = word;
      // flops may still be unknown before the first edge
      if (a > 0) begin
        check_value("dec_valid_o in reset", 32'(dec_valid_o), 32'd0);
      end
    end
    @(posedge clk_i);
    load_we_i <= 1'b0;
  endtask

  task automatic finish_test(input string name, input int unsigned err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %-12s ok", name);
    end else begin
      tests_failed++;
      $display("test %-12s FAILED with %0d errors", name, errors - err_before);
    end
  endtask

  initial begin
    int unsigned err_before;
    rst_ni        = 1'b0;
    load_we_i     = 1'b0;
    load_addr_i   = '0;
    load_data_i   = '0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    dec_ready_i   = 1'b0;
    exp_pc        = fe_pkg::RESET_PC;
    void'($urandom(SEED));

    // memory is loaded while the core is held in reset
    err_before = errors;
    load_memory();
    repeat (RESET_CYCLES) begin
      @(posedge clk_i);
      check_value("dec_valid_o in reset", 32'(dec_valid_o), 32'd0);
    end
    rst_ni      <= 1'b1;
    dec_ready_i <= 1'b1;
    @(posedge clk_i);
    check_value("dec_valid_o after reset", 32'(dec_valid_o), 32'd0);
    finish_test("reset_state", err_before);

    // straight stream from reset pc, then across the 1 KiB wrap
    err_before = errors;
    wait_bundles(40, 1'b0, "sequential");
    issue_redirect(32'h0000_03C4, 1'b0);
    wait_bundles(20, 1'b0, "wrap");
    finish_test("sequential", err_before);

    err_before = errors;
    wait_bundles(60, 1'b1, "backpressure");
    finish_test("backpressure", err_before);

    err_before = errors;
    for (int k = 0; k < 3; k++) begin
      wait_bundles(4, 1'b0, "redirect");
      issue_redirect($urandom(), 1'b0);
      wait_bundles(8, 1'b0, "redirect");
    end
    finish_test("redirect", err_before);

    err_before = errors;
    for (int k = 0; k < 3; k++) begin
      wait_bundles(4, 1'b1, "redirect_bp");
      issue_redirect($urandom(), 1'b1);
      wait_bundles(8, 1'b1, "redirect_bp");
    end
    finish_test("redirect_bp", err_before);

    // every class must have gone through the decoder by now
    err_before = errors;
    wait_bundles(30, 1'b0, "decode");
    for (int c = 0; c <= int'(fe_pkg::OPC_ILLEGAL); c++) begin
      if (!class_seen[c]) begin
        errors++;
        $display("opcode class %0d was never delivered", c);
      end
    end
    finish_test("decode", err_before);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
